// File: source/gfx_pkg.sv
`default_nettype none

package gfx_pkg;

  // horizontal timing, in pixels
  localparam int h_visible = 16;
  localparam int h_front   = 2;
  localparam int h_sync    = 3;
  localparam int h_back    = 3;
  localparam int h_whole   = 24;

  // vertical timing, in lines
  localparam int v_visible = 12;
  localparam int v_front   = 1;
  localparam int v_sync    = 2;
  localparam int v_back    = 1;
  localparam int v_whole   = 16;

  // one word per visible pixel
  localparam int fb_words = 192;

  // clock crossing fifo depth and fill threshold
  localparam int fifo_addr_bits         = 4;
  localparam int fifo_almost_full_level = 12;

  typedef logic [3:0]  fb_x_t;
  typedef logic [3:0]  fb_y_t;
  // red in the top nibble, then green, then blue
  typedef logic [11:0] pixel_t;
  typedef logic [3:0]  channel_t;
  // y * 16 + x
  typedef logic [7:0]  fb_addr_t;
  typedef logic [15:0] axi_data_t;
  // okay is zero
  typedef logic [1:0]  axi_resp_t;
  typedef logic [4:0]  h_count_t;
  typedef logic [3:0]  v_count_t;
  // {hsync_n, vsync_n, pixel}
  typedef logic [13:0] vga_word_t;

  typedef enum logic [1:0] {idle, send, resp} writer_state_t;
  typedef enum logic {run, read_wait} stream_state_t;

endpackage

`default_nettype wire

// File: source/fb_writer.sv
`timescale 1ns/1ps
`default_nettype none

module fb_writer
  import gfx_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  input  fb_x_t     gfx_x,
  input  fb_y_t     gfx_y,
  input  pixel_t    gfx_color,
  input  logic      gfx_valid,
  output logic      gfx_ready,

  output fb_addr_t  awaddr,
  output logic      awvalid,
  output axi_data_t wdata,
  output logic [1:0] wstrb,
  output logic      wvalid,
  output logic      bready,

  input  logic      awready,
  input  logic      wready,
  input  logic      bvalid,
  input  axi_resp_t bresp
);

  writer_state_t state;

  assign gfx_ready = (state == idle);
  assign bready    = (state == resp);
  // whole pixel word every time
  assign wstrb     = 2'b11;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= idle;
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (gfx_valid) begin
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
            state   <= send;
          end
        end
        send: begin
          // aw and w may complete on different edges
          if (awready) begin
            awvalid <= 1'b0;
          end
          if (wready) begin
            wvalid <= 1'b0;
          end
          if ((awready || !awvalid) && (wready || !wvalid)) begin
            state <= resp;
          end
        end
        resp: begin
          if (bvalid) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // line length is 16, so the address is just {y, x}
  always_ff @(posedge clk) begin
    if (gfx_valid && gfx_ready) begin
      awaddr <= {gfx_y, gfx_x};
      wdata  <= axi_data_t'(gfx_color);
    end
  end

  a_aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
    awvalid && !awready |=> awvalid)
    else $error("awvalid dropped before awready");

  a_bresp_okay: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid |-> bresp == '0)
    else $error("write response is not okay");

endmodule

`default_nettype wire

// File: source/fb_memory.sv
`timescale 1ns/1ps
`default_nettype none

module fb_memory
  import gfx_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  // write channels
  input  fb_addr_t   awaddr,
  input  logic       awvalid,
  output logic       awready,
  input  axi_data_t  wdata,
  input  logic [1:0] wstrb,
  input  logic       wvalid,
  output logic       wready,
  output logic       bvalid,
  output axi_resp_t  bresp,
  input  logic       bready,

  // read channels
  input  fb_addr_t   araddr,
  input  logic       arvalid,
  output logic       arready,
  output axi_data_t  rdata,
  output logic       rvalid,
  output axi_resp_t  rresp,
  input  logic       rready
);

  axi_data_t mem [fb_words];

  logic wr_fire;
  logic rd_fire;

  // take aw and w together, one response outstanding at most
  assign wr_fire = awvalid && wvalid && !bvalid;
  assign awready = wr_fire;
  assign wready  = wr_fire;
  assign bresp   = '0;

  assign arready = !rvalid;
  assign rd_fire = arvalid && arready;
  assign rresp   = '0;

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      if (wstrb[0]) begin
        mem[awaddr][7:0] <= wdata[7:0];
      end
      if (wstrb[1]) begin
        mem[awaddr][15:8] <= wdata[15:8];
      end
    end
  end

  // registered read port
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata <= mem[araddr];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      if (wr_fire) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      if (rd_fire) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  a_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
    (!wr_fire || awaddr < fb_addr_t'(fb_words)) &&
    (!rd_fire || araddr < fb_addr_t'(fb_words)))
    else $error("framebuffer address out of range");

endmodule

`default_nettype wire

// File: source/fb_pixel_stream.sv
`timescale 1ns/1ps
`default_nettype none

module fb_pixel_stream
  import gfx_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // read channels toward the framebuffer
  output fb_addr_t  araddr,
  output logic      arvalid,
  output logic      rready,
  input  logic      arready,
  input  axi_data_t rdata,
  input  logic      rvalid,
  input  axi_resp_t rresp,

  // toward the fifo
  output logic      push,
  output vga_word_t push_word,
  input  logic      almost_full,

  output logic      gfx_vsync
);

  localparam h_count_t h_last     = h_count_t'(h_whole - 1);
  localparam h_count_t hs_start   = h_count_t'(h_visible + h_front);
  localparam h_count_t hs_end     = h_count_t'(h_visible + h_front + h_sync);
  localparam v_count_t v_last     = v_count_t'(v_whole - 1);
  localparam v_count_t vs_start   = v_count_t'(v_visible + v_front);
  localparam v_count_t vs_end     = v_count_t'(v_visible + v_front + v_sync);
  localparam h_count_t h_vis_end  = h_count_t'(h_visible);
  localparam v_count_t v_vis_end  = v_count_t'(v_visible);

  stream_state_t state;
  h_count_t      h_count;
  v_count_t      v_count;

  logic   visible;
  logic   hsync_n;
  logic   vsync_n;
  logic   blank_step;
  logic   read_done;
  logic   step_done;
  logic   step_af;
  pixel_t color;

  // position decode
  assign visible = (h_count < h_vis_end) && (v_count < v_vis_end);
  assign hsync_n = !((h_count >= hs_start) && (h_count < hs_end));
  assign vsync_n = !((v_count >= vs_start) && (v_count < vs_end));
  assign gfx_vsync = !vsync_n;

  // only meaningful while visible
  assign araddr = {v_count, h_count[3:0]};
  assign rready = (state == read_wait);

  assign blank_step = (state == run) && !almost_full && !visible;
  assign read_done  = (state == read_wait) && rvalid && rready;
  assign step_done  = blank_step || read_done;

  // error response shows as black
  assign color = (read_done && rresp == '0) ? pixel_t'(rdata) : '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= run;
      arvalid <= 1'b0;
      push    <= 1'b0;
      step_af <= 1'b0;
    end else begin
      push <= step_done;
      case (state)
        run: begin
          step_af <= almost_full;
          if (!almost_full && visible) begin
            arvalid <= 1'b1;
            state   <= read_wait;
          end
        end
        read_wait: begin
          if (arready) begin
            arvalid <= 1'b0;
          end
          if (read_done) begin
            state <= run;
          end
        end
        default: state <= run;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (step_done) begin
      push_word <= {hsync_n, vsync_n, color};
    end
  end

  // raster position, advanced once per pushed entry
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      h_count <= '0;
      v_count <= '0;
    end else if (step_done) begin
      if (h_count == h_last) begin
        h_count <= '0;
        v_count <= (v_count == v_last) ? '0 : v_count + v_count_t'(1);
      end else begin
        h_count <= h_count + h_count_t'(1);
      end
    end
  end

  a_push_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> !step_af)
    else $error("pixel pushed for a step begun while the fifo was almost full");

endmodule

`default_nettype wire

// File: source/cdc_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo
  import gfx_pkg::*;
(
  input  logic      clk,
  input  logic      pixel_clk,
  input  logic      rst_n,

  // write side, clk domain
  input  logic      push,
  input  vga_word_t push_word,
  output logic      almost_full,

  // vga pins, pixel_clk domain
  output channel_t  vga_red,
  output channel_t  vga_grn,
  output channel_t  vga_blu,
  output logic      vga_hsync,
  output logic      vga_vsync
);

  localparam int ptr_bits = fifo_addr_bits + 1;
  typedef logic [ptr_bits-1:0] ptr_t;

  vga_word_t mem [2**fifo_addr_bits];

  ptr_t w_bin, w_gray, w_bin_next, r_gray_q1, r_gray_q2, r_bin_sync, fill;
  ptr_t r_bin, r_gray, r_bin_next, w_gray_q1, w_gray_q2;
  logic full;
  logic wr_en;
  logic empty;
  logic started;
  vga_word_t out_word;

  function automatic ptr_t to_gray(ptr_t b);
    return b ^ (b >> 1);
  endfunction

  function automatic ptr_t to_bin(ptr_t g);
    ptr_t b;
    b[ptr_bits-1] = g[ptr_bits-1];
    for (int i = ptr_bits - 2; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  // write side
  assign w_bin_next  = w_bin + ptr_t'(1);
  // full when the top two gray bits differ and the rest match
  assign full        = (w_gray == {~r_gray_q2[ptr_bits-1 -: 2], r_gray_q2[ptr_bits-3:0]});
  assign wr_en       = push && !full;
  assign r_bin_sync  = to_bin(r_gray_q2);
  // pessimistic, the read pointer seen here lags
  assign fill        = w_bin - r_bin_sync;
  assign almost_full = (fill >= ptr_t'(fifo_almost_full_level));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      w_bin     <= '0;
      w_gray    <= '0;
      r_gray_q1 <= '0;
      r_gray_q2 <= '0;
    end else begin
      r_gray_q1 <= r_gray;
      r_gray_q2 <= r_gray_q1;
      if (wr_en) begin
        w_bin  <= w_bin_next;
        w_gray <= to_gray(w_bin_next);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[w_bin[fifo_addr_bits-1:0]] <= push_word;
    end
  end

  // read side, free running once started
  assign r_bin_next = r_bin + ptr_t'(1);
  assign empty      = (r_gray == w_gray_q2);

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      r_bin     <= '0;
      r_gray    <= '0;
      w_gray_q1 <= '0;
      w_gray_q2 <= '0;
      started   <= 1'b0;
      // idle pins: syncs inactive, black
      out_word  <= {1'b1, 1'b1, pixel_t'(0)};
    end else begin
      w_gray_q1 <= w_gray;
      w_gray_q2 <= w_gray_q1;
      if (!empty) begin
        started <= 1'b1;
      end
      if (started) begin
        r_bin    <= r_bin_next;
        r_gray   <= to_gray(r_bin_next);
        out_word <= mem[r_bin[fifo_addr_bits-1:0]];
      end
    end
  end

  assign {vga_hsync, vga_vsync, vga_red, vga_grn, vga_blu} = out_word;

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> !full)
    else $error("push while the fifo is full");

  a_no_underflow: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    started |-> !empty)
    else $error("fifo ran empty after the display started");

endmodule

`default_nettype wire

// File: source/gfx_display.sv
`timescale 1ns/1ps
`default_nettype none

module gfx_display
  import gfx_pkg::*;
(
  input  logic     clk,
  input  logic     pixel_clk,
  input  logic     rst_n,

  // drawing client
  input  fb_x_t    gfx_x,
  input  fb_y_t    gfx_y,
  input  pixel_t   gfx_color,
  input  logic     gfx_valid,
  output logic     gfx_ready,
  output logic     gfx_vsync,

  // vga pins
  output channel_t vga_red,
  output channel_t vga_grn,
  output channel_t vga_blu,
  output logic     vga_hsync,
  output logic     vga_vsync
);

  // writer to memory
  fb_addr_t   awaddr;
  logic       awvalid;
  logic       awready;
  axi_data_t  wdata;
  logic [1:0] wstrb;
  logic       wvalid;
  logic       wready;
  logic       bvalid;
  logic       bready;
  axi_resp_t  bresp;

  // stream to memory
  fb_addr_t   araddr;
  logic       arvalid;
  logic       arready;
  axi_data_t  rdata;
  logic       rvalid;
  logic       rready;
  axi_resp_t  rresp;

  // stream to fifo
  logic       push;
  vga_word_t  push_word;
  logic       almost_full;

  fb_writer u_writer (
    .clk      (clk),
    .rst_n    (rst_n),
    .gfx_x    (gfx_x),
    .gfx_y    (gfx_y),
    .gfx_color(gfx_color),
    .gfx_valid(gfx_valid),
    .gfx_ready(gfx_ready),
    .awaddr   (awaddr),
    .awvalid  (awvalid),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .wvalid   (wvalid),
    .bready   (bready),
    .awready  (awready),
    .wready   (wready),
    .bvalid   (bvalid),
    .bresp    (bresp)
  );

  fb_memory u_memory (
    .clk    (clk),
    .rst_n  (rst_n),
    .awaddr (awaddr),
    .awvalid(awvalid),
    .awready(awready),
    .wdata  (wdata),
    .wstrb  (wstrb),
    .wvalid (wvalid),
    .wready (wready),
    .bvalid (bvalid),
    .bresp  (bresp),
    .bready (bready),
    .araddr (araddr),
    .arvalid(arvalid),
    .arready(arready),
    .rdata  (rdata),
    .rvalid (rvalid),
    .rresp  (rresp),
    .rready (rready)
  );

  fb_pixel_stream u_stream (
    .clk        (clk),
    .rst_n      (rst_n),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .rready     (rready),
    .arready    (arready),
    .rdata      (rdata),
    .rvalid     (rvalid),
    .rresp      (rresp),
    .push       (push),
    .push_word  (push_word),
    .almost_full(almost_full),
    .gfx_vsync  (gfx_vsync)
  );

  // crossing into the pixel clock
  cdc_fifo u_fifo (
    .clk        (clk),
    .pixel_clk  (pixel_clk),
    .rst_n      (rst_n),
    .push       (push),
    .push_word  (push_word),
    .almost_full(almost_full),
    .vga_red    (vga_red),
    .vga_grn    (vga_grn),
    .vga_blu    (vga_blu),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync)
  );

endmodule

`default_nettype wire

// File: dv/tb_gfx_display.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gfx_display
  import gfx_pkg::*;
();

  localparam int reset_cycles = 10;
  localparam int line_pix     = h_whole;
  localparam int frame_pix    = h_whole * v_whole;
  // stream runs in step with the display once the fifo has filled
  localparam int line_clks    = 3 * h_whole;
  localparam int slack_clks   = 3 * (2**fifo_addr_bits);

  logic clk;
  logic pixel_clk;
  logic rst_n;
  fb_x_t gfx_x;
  fb_y_t gfx_y;
  pixel_t gfx_color;
  logic gfx_valid;
  logic gfx_ready;
  logic gfx_vsync;
  channel_t vga_red;
  channel_t vga_grn;
  channel_t vga_blu;
  logic vga_hsync;
  logic vga_vsync;

  int errors = 0;
  int pixel_checks = 0;
  integer seed = 32'h374d;
  pixel_t shadow [fb_words];
  logic known [fb_words];
  int clk_rst_edges = 0;
  int pix_rst_edges = 0;

  gfx_display DUT (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    pixel_clk = 1'b0;
    forever #60 pixel_clk = ~pixel_clk;
  end

  always @(posedge clk) if (!rst_n) clk_rst_edges <= clk_rst_edges + 1;
  always @(posedge pixel_clk) if (!rst_n) pix_rst_edges <= pix_rst_edges + 1;

  // pins idle and client ready while held in reset
  a_idle_pins: assert property (@(posedge pixel_clk)
    (!rst_n && pix_rst_edges >= 1) |-> (vga_hsync && vga_vsync &&
      vga_red == '0 && vga_grn == '0 && vga_blu == '0))
    else begin
      errors++;
      $display("vga pins are not idle during reset");
    end

  a_ready_reset: assert property (@(posedge clk)
    (!rst_n && clk_rst_edges >= 1) |-> gfx_ready)
    else begin
      errors++;
      $display("gfx_ready is not high during reset");
    end

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
      errors++;
      $display("FAILED %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // output raster monitor, positions recovered from the sync edges
  int pix_cycle = 0;
  int col = 0;
  int row = 0;
  bit h_known = 0;
  bit v_known = 0;
  logic prev_hs = 1'b1;
  logic prev_vs = 1'b1;
  int last_hfall = -1;
  int last_vfall = -1;
  int hlow = 0;
  int vlow = 0;
  int hpulses = 0;

  always @(negedge pixel_clk) begin
    int addr;
    if (rst_n) begin
      pix_cycle++;
      if (!vga_hsync && prev_hs) begin
        if (last_hfall >= 0) check_value("vga_hsync period", line_pix, pix_cycle - last_hfall);
        last_hfall = pix_cycle;
        hlow = 0;
        hpulses++;
      end
      if (!vga_hsync) hlow++;
      if (!vga_vsync && prev_vs) begin
        if (last_vfall >= 0) check_value("vga_vsync period", frame_pix, pix_cycle - last_vfall);
        last_vfall = pix_cycle;
        vlow = 0;
      end
      if (!vga_vsync) vlow++;
      if (vga_hsync && !prev_hs) begin
        check_value("vga_hsync low length", h_sync, hlow);
        col = h_visible + h_front + h_sync;
        h_known = 1;
      end else if (h_known) begin
        if (col == h_whole - 1) begin
          col = 0;
          row = (row == v_whole - 1) ? 0 : row + 1;
        end else begin
          col++;
        end
      end
      if (vga_vsync && !prev_vs) begin
        check_value("vga_vsync low length", v_sync * h_whole, vlow);
        // the rise shows the first pixel of the back porch line
        row = v_visible + v_front + v_sync;
        v_known = 1;
      end
      prev_hs = vga_hsync;
      prev_vs = vga_vsync;
      if (h_known && v_known) begin
        if (col < h_visible && row < v_visible) begin
          addr = row * h_visible + col;
          if (known[addr]) begin
            pixel_checks++;
            check_value("vga_red", int'(shadow[addr][11:8]), int'(vga_red));
            check_value("vga_grn", int'(shadow[addr][7:4]), int'(vga_grn));
            check_value("vga_blu", int'(shadow[addr][3:0]), int'(vga_blu));
          end
        end else begin
          check_value("vga_red", 0, int'(vga_red));
          check_value("vga_grn", 0, int'(vga_grn));
          check_value("vga_blu", 0, int'(vga_blu));
        end
      end
    end
  end

  // gfx_vsync in clk time
  int clk_cycle = 0;
  int last_gv_rise = -1;
  int gv_len = 0;
  logic prev_gv = 1'b0;

  always @(negedge clk) begin
    int diff;
    if (rst_n) begin
      clk_cycle++;
      if (gfx_vsync && !prev_gv) begin
        if (last_gv_rise >= 0) begin
          diff = clk_cycle - last_gv_rise;
          if (diff < 3 * frame_pix - slack_clks || diff > 3 * frame_pix + slack_clks) begin
            errors++;
            $display("gfx_vsync period of %0d clk cycles is not one frame", diff);
          end
        end
        last_gv_rise = clk_cycle;
        gv_len = 0;
      end
      if (gfx_vsync) gv_len++;
      if (!gfx_vsync && prev_gv) begin
        if (gv_len < v_sync * line_clks - slack_clks ||
            gv_len > v_sync * line_clks + slack_clks) begin
          errors++;
          $display("gfx_vsync high for %0d clk cycles, not two lines", gv_len);
        end
      end
      prev_gv = gfx_vsync;
    end
  end

  // caller sits 5 ns after a clk edge, and so does the return
  task automatic write_pixel(input int x, input int y, input int c);
    int addr;
    addr = y * h_visible + x;
    gfx_x = fb_x_t'(x);
    gfx_y = fb_y_t'(y);
    gfx_color = pixel_t'(c);
    gfx_valid = 1'b1;
    // held until the next edge sees ready high
    while (!gfx_ready) begin
      @(posedge clk);
      #5;
    end
    @(posedge clk);
    shadow[addr] = pixel_t'(c);
    known[addr] = 1'b1;
    #5;
    gfx_valid = 1'b0;
  endtask

  task automatic wait_vsync_rise();
    while (gfx_vsync) begin
      @(posedge clk);
      #5;
    end
    while (!gfx_vsync) begin
      @(posedge clk);
      #5;
    end
  endtask

  task automatic draw_during_vsync();
    int x;
    int y;
    wait_vsync_rise();
    for (int i = 0; i < 16; i++) begin
      if (gfx_vsync) begin
        x = ($random(seed) & 32'h7fffffff) % h_visible;
        y = ($random(seed) & 32'h7fffffff) % v_visible;
        write_pixel(x, y, $random(seed) & 32'hfff);
      end
    end
    // same pixel over and over, the last colour must win
    x = ($random(seed) & 32'h7fffffff) % h_visible;
    y = ($random(seed) & 32'h7fffffff) % v_visible;
    for (int i = 0; i < 4; i++) begin
      if (gfx_vsync) write_pixel(x, y, $random(seed) & 32'hfff);
    end
  endtask

  initial begin
    #(reset_cycles * 40 + 6 * frame_pix * 120);
    $display("timeout: display did not finish the expected frames");
    $display("tests failed");
    $finish;
  end

  initial begin
    for (int i = 0; i < fb_words; i++) begin
      known[i] = 1'b0;
      shadow[i] = '0;
    end
    rst_n = 1'b0;
    gfx_x = '0;
    gfx_y = '0;
    gfx_color = '0;
    gfx_valid = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #5;
    rst_n = 1'b1;
    repeat (3) draw_during_vsync();
    repeat (2) wait_vsync_rise();
    if (pixel_checks == 0) begin
      errors++;
      $display("no drawn pixel was ever shown on the display");
    end
    if (hpulses == 0) begin
      errors++;
      $display("no hsync pulse seen on the display");
    end
    $display("errors: %0d, pixels checked: %0d", errors, pixel_checks);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
source/gfx_pkg.sv
source/fb_writer.sv
source/fb_memory.sv
source/fb_pixel_stream.sv
source/cdc_fifo.sv
source/gfx_display.sv
dv/tb_gfx_display.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_gfx_display \
  -f list.f -o sim_gfx_display

./obj_dir/sim_gfx_display > sim.log 2>&1 || true
cat sim.log

if grep -q "all tests passed" sim.log; then
  echo "simulation PASS"
else
  echo "simulation FAIL"
  exit 1
fi
